/* verilog.f */
hdl/dcache_pkg.sv
hdl/dcache_port_issue.sv
hdl/dcache_port_ctrl.sv
hdl/dcache_store.sv
hdl/dcache_bus_arb.sv
hdl/dcache_top.sv
verification/dcache_tb.sv

/* verification/dcache_tb.sv */
// Directed testbench for the two-port data cache with a bus memory model
`timescale 1ns/1ps

module dcache_tb;

    localparam int N_OPS     = 83;                  // Port ops issued over all tests
    localparam int MEM_WORDS = 1024;                // 4 KB behind the bus
    localparam int LIMIT_CYC = N_OPS * 12 + 200;

    logic                       clk;
    logic                       rst;
    dcache_pkg::lsu_op_e        op_p0_i;
    dcache_pkg::lsu_op_e        op_p1_i;
    logic [31:0]                addr_p0_i;
    logic [31:0]                addr_p1_i;
    logic [31:0]                wdata_p0_i;
    logic [31:0]                wdata_p1_i;
    logic [31:0]                rdata_p0_o;
    logic [31:0]                rdata_p1_o;
    logic                       freeze_o;
    logic                       bus_rq_o;
    logic                       bus_we_o;
    logic [31:0]                bus_addr_o;
    logic [3:0]                 bus_sel_o;
    logic [31:0]                bus_wdata_o;
    logic [31:0]                bus_rdata_i;
    logic                       bus_rdy_i;

    logic [31:0]                mem       [MEM_WORDS];
    logic [31:0]                shadow    [MEM_WORDS];  // Expected memory contents
    logic [31:0]                exp_rdata [2];
    logic [1:0]                 rdata_known;
    logic [31:0]                bus_addrs [$];
    logic                       last_we;
    logic [3:0]                 last_sel;
    logic [31:0]                last_wdata;
    logic                       saw_freeze;
    logic                       saw_bus;
    int                         seed = 85305;

    dcache_top u_dut (
        .clk(clk), .rst(rst),
        .op_p0_i(op_p0_i), .addr_p0_i(addr_p0_i), .wdata_p0_i(wdata_p0_i),
        .rdata_p0_o(rdata_p0_o),
        .op_p1_i(op_p1_i), .addr_p1_i(addr_p1_i), .wdata_p1_i(wdata_p1_i),
        .rdata_p1_o(rdata_p1_o),
        .freeze_o(freeze_o),
        .bus_rq_o(bus_rq_o), .bus_we_o(bus_we_o), .bus_addr_o(bus_addr_o),
        .bus_sel_o(bus_sel_o), .bus_wdata_o(bus_wdata_o),
        .bus_rdata_i(bus_rdata_i), .bus_rdy_i(bus_rdy_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] fill_word(int unsigned wi);
        logic [31:0] a;
        a = wi << 2;
        return (a * 32'h9E37_79B1) ^ 32'h5A3C_0F96;
    endfunction

    function automatic logic [3:0] lanes_for(dcache_pkg::lsu_op_e op, logic [1:0] lo);
        case (op)
            dcache_pkg::LB, dcache_pkg::LBU, dcache_pkg::SB: return 4'b0001 << lo;
            dcache_pkg::LH, dcache_pkg::LHU, dcache_pkg::SH: return 4'b0011 << {lo[1], 1'b0};
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] lane_bits(logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // Replicate then mask, other lanes zero
    function automatic logic [31:0] place_store(dcache_pkg::lsu_op_e op, logic [1:0] lo,
                                                logic [31:0] d);
        case (op)
            dcache_pkg::SB: return {4{d[7:0]}} & lane_bits(lanes_for(op, lo));
            dcache_pkg::SH: return {2{d[15:0]}} & lane_bits(lanes_for(op, lo));
            default:        return d;
        endcase
    endfunction

    function automatic logic [31:0] expect_load(dcache_pkg::lsu_op_e op, logic [1:0] lo,
                                                logic [31:0] w);
        logic [31:0] sh;
        sh = w >> (8 * lo);
        case (op)
            dcache_pkg::LB:  return 32'($signed(sh[7:0]));
            dcache_pkg::LBU: return 32'(sh[7:0]);
            dcache_pkg::LH:  return 32'($signed(sh[15:0]));
            dcache_pkg::LHU: return 32'(sh[15:0]);
            default:         return w;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking and bus memory
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s is 0x%h, expected 0x%h",
                               $time, name, got, exp));
        end
    endtask

    always begin : bus_model
        int          wait_cyc;
        logic [31:0] b_addr;
        logic [31:0] b_wdata;
        logic [3:0]  b_sel;
        logic        b_we;
        @(negedge clk);
        if (bus_rq_o) begin
            saw_bus = 1'b1;
            bus_addrs.push_back(bus_addr_o);
            if (bus_addr_o[31:12] != '0) fail_run("Bus address lies outside the memory model");
            wait_cyc = 1 + {$random(seed)} % 4;
            repeat (wait_cyc - 1) @(negedge clk);
            b_we    = bus_we_o;
            b_addr  = bus_addr_o;
            b_sel   = bus_sel_o;
            b_wdata = bus_wdata_o;
            last_we    = b_we;
            last_sel   = b_sel;
            last_wdata = b_wdata;
            @(posedge clk);
            bus_rdy_i   <= 1'b1;
            bus_rdata_i <= mem[b_addr[11:2]];
            @(posedge clk);
            bus_rdy_i <= 1'b0;
            for (int l = 0; l < 4; l++) begin
                if (b_we && b_sel[l]) mem[b_addr[11:2]][l*8 +: 8] = b_wdata[l*8 +: 8];
            end
        end
    end

    initial begin
        #(LIMIT_CYC * 10);
        fail_run("Timeout: the tests did not finish in the allowed number of cycles");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Op driver and tests
    ////////////////////////////////////////////////////////////////////////////

    // Port 0 takes effect before port 1
    task automatic apply_op(input int p, input dcache_pkg::lsu_op_e op, input logic [31:0] a,
                            input logic [31:0] d);
        logic [31:0] m;
        m = lane_bits(lanes_for(op, a[1:0]));
        if (op inside {dcache_pkg::LB, dcache_pkg::LBU, dcache_pkg::LH, dcache_pkg::LHU,
                       dcache_pkg::LW}) begin
            exp_rdata[p]   = expect_load(op, a[1:0], shadow[a[11:2]]);
            rdata_known[p] = 1'b1;
        end else if (op inside {dcache_pkg::SB, dcache_pkg::SH, dcache_pkg::SW}) begin
            shadow[a[11:2]] = (shadow[a[11:2]] & ~m) | (place_store(op, a[1:0], d) & m);
        end
    endtask

    task automatic run_ops(input dcache_pkg::lsu_op_e o0, input logic [31:0] a0,
                           input logic [31:0] d0, input dcache_pkg::lsu_op_e o1,
                           input logic [31:0] a1, input logic [31:0] d1);
        apply_op(0, o0, a0, d0);
        apply_op(1, o1, a1, d1);
        saw_freeze = 1'b0;
        saw_bus    = 1'b0;
        bus_addrs.delete();
        @(posedge clk);
        op_p0_i    <= o0;
        addr_p0_i  <= a0;
        wdata_p0_i <= d0;
        op_p1_i    <= o1;
        addr_p1_i  <= a1;
        wdata_p1_i <= d1;
        @(negedge clk);
        while (freeze_o) @(negedge clk);
        @(posedge clk);                     // Capture edge
        op_p0_i <= dcache_pkg::NOP;
        op_p1_i <= dcache_pkg::NOP;
        @(negedge clk);
        while (freeze_o) begin
            saw_freeze = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        if (rdata_known[0]) check_value("rdata_p0_o", rdata_p0_o, exp_rdata[0]);
        if (rdata_known[1]) check_value("rdata_p1_o", rdata_p1_o, exp_rdata[1]);
    endtask

    task automatic check_store(input dcache_pkg::lsu_op_e op, input logic [31:0] a,
                               input logic [31:0] d);
        check_value("bus transactions", bus_addrs.size(), 32'd1);
        check_value("bus_addr_o", bus_addrs[0], {a[31:2], 2'b00});
        check_value("bus_we_o", 32'(last_we), 32'd1);
        check_value("bus_sel_o", 32'(last_sel), 32'(lanes_for(op, a[1:0])));
        check_value("bus_wdata_o", last_wdata, place_store(op, a[1:0], d));
        check_value("memory word", mem[a[11:2]], shadow[a[11:2]]);
    endtask

    task automatic test_miss_then_hit();
        run_ops(dcache_pkg::LW, 32'h104, 32'd0, dcache_pkg::NOP, 32'd0, 32'd0);
        check_value("freeze_o", 32'(saw_freeze), 32'd1);
        check_value("bus transactions", bus_addrs.size(), 32'd1);
        run_ops(dcache_pkg::LW, 32'h104, 32'd0, dcache_pkg::NOP, 32'd0, 32'd0);
        check_value("freeze_o", 32'(saw_freeze), 32'd0);
        check_value("bus_rq_o", 32'(saw_bus), 32'd0);
    endtask

    task automatic test_load_extend();
        logic [31:0] pats [2];
        pats[0] = 32'h807F_FE01;            // Negative halves
        pats[1] = 32'h7F80_01FE;
        for (int k = 0; k < 2; k++) begin
            run_ops(dcache_pkg::SW, 32'h120, pats[k], dcache_pkg::NOP, 32'd0, 32'd0);
            run_ops(dcache_pkg::LW, 32'h120, 32'd0, dcache_pkg::NOP, 32'd0, 32'd0);
            for (int l = 0; l < 4; l++) begin
                run_ops(dcache_pkg::LB, 32'h120 + l, 32'd0, dcache_pkg::LBU, 32'h120 + l, 32'd0);
                check_value("freeze_o", 32'(saw_freeze), 32'd0);
            end
            for (int l = 0; l < 4; l += 2) begin
                run_ops(dcache_pkg::LH, 32'h120 + l, 32'd0, dcache_pkg::LHU, 32'h120 + l, 32'd0);
                check_value("freeze_o", 32'(saw_freeze), 32'd0);
            end
        end
    endtask

    task automatic test_store_merge();
        run_ops(dcache_pkg::LW, 32'h140, 32'd0, dcache_pkg::NOP, 32'd0, 32'd0);
        run_ops(dcache_pkg::SB, 32'h141, 32'h1234_56A5, dcache_pkg::NOP, 32'd0, 32'd0);
        check_store(dcache_pkg::SB, 32'h141, 32'h1234_56A5);
        run_ops(dcache_pkg::NOP, 32'd0, 32'd0, dcache_pkg::SH, 32'h142, 32'hFFFF_C3D2);
        check_store(dcache_pkg::SH, 32'h142, 32'hFFFF_C3D2);
        run_ops(dcache_pkg::SW, 32'h344, 32'h0BAD_F00D, dcache_pkg::NOP, 32'd0, 32'd0);
        check_store(dcache_pkg::SW, 32'h344, 32'h0BAD_F00D);
        run_ops(dcache_pkg::LW, 32'h140, 32'd0, dcache_pkg::LW, 32'h140, 32'd0);
        run_ops(dcache_pkg::LW, 32'h344, 32'd0, dcache_pkg::LW, 32'h344, 32'd0);
    endtask

    task automatic test_store_load_same();
        run_ops(dcache_pkg::NOP, 32'd0, 32'd0, dcache_pkg::LW, 32'h180, 32'd0);
        run_ops(dcache_pkg::SW, 32'h180, 32'hC0DE_1234, dcache_pkg::LW, 32'h180, 32'd0);
        check_value("freeze_o", 32'(saw_freeze), 32'd1);
        check_store(dcache_pkg::SW, 32'h180, 32'hC0DE_1234);
    endtask

    task automatic test_dual_miss();
        run_ops(dcache_pkg::LW, 32'h1A8, 32'd0, dcache_pkg::LW, 32'h3C4, 32'd0);
        check_value("bus transactions", bus_addrs.size(), 32'd2);
        check_value("bus_addr_o", bus_addrs[0], 32'h1A8);   // Port 0 served first
        check_value("bus_addr_o", bus_addrs[1], 32'h3C4);
    endtask

    task automatic test_random_mix();
        dcache_pkg::lsu_op_e op [2];
        logic [31:0]         a  [2];
        logic [31:0]         d  [2];
        logic [1:0]          lo;
        for (int i = 0; i < 20; i++) begin
            for (int p = 0; p < 2; p++) begin
                op[p] = dcache_pkg::lsu_op_e'(4'(1 + {$random(seed)} % 8));
                case (op[p])
                    dcache_pkg::LB, dcache_pkg::LBU, dcache_pkg::SB: lo = 2'({$random(seed)} % 4);
                    dcache_pkg::LH, dcache_pkg::LHU, dcache_pkg::SH:
                        lo = {1'({$random(seed)} % 2), 1'b0};
                    default: lo = 2'b00;
                endcase
                // Two tags over four line indices
                a[p] = {22'd0, 1'({$random(seed)} % 2), 5'd0, 2'({$random(seed)} % 4), lo};
                d[p] = $random(seed);
            end
            run_ops(op[0], a[0], d[0], op[1], a[1], d[1]);
        end
    endtask

    initial begin
        rst         = 1'b1;
        op_p0_i     = dcache_pkg::NOP;
        op_p1_i     = dcache_pkg::NOP;
        addr_p0_i   = '0;
        addr_p1_i   = '0;
        wdata_p0_i  = '0;
        wdata_p1_i  = '0;
        bus_rdata_i = '0;
        bus_rdy_i   = 1'b0;
        rdata_known = '0;
        saw_freeze  = 1'b0;
        saw_bus     = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = mem[i];
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_miss_then_hit();
        test_load_extend();
        test_store_merge();
        test_store_load_same();
        test_dual_miss();
        test_random_mix();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* hdl/dcache_top.sv */
// Two-port write-through data cache with a shared line store and one bus
`timescale 1ns/1ps

module dcache_top (
    input  logic                                clk,
    input  logic                                rst,
    input  dcache_pkg::lsu_op_e                 op_p0_i,
    input  logic [dcache_pkg::ADDR_W-1:0]       addr_p0_i,
    input  logic [dcache_pkg::DATA_W-1:0]       wdata_p0_i,
    output logic [dcache_pkg::DATA_W-1:0]       rdata_p0_o,
    input  dcache_pkg::lsu_op_e                 op_p1_i,
    input  logic [dcache_pkg::ADDR_W-1:0]       addr_p1_i,
    input  logic [dcache_pkg::DATA_W-1:0]       wdata_p1_i,
    output logic [dcache_pkg::DATA_W-1:0]       rdata_p1_o,
    output logic                                freeze_o,
    output logic                                bus_rq_o,
    output logic                                bus_we_o,
    output logic [dcache_pkg::ADDR_W-1:0]       bus_addr_o,
    output logic [dcache_pkg::N_LANES-1:0]      bus_sel_o,
    output logic [dcache_pkg::DATA_W-1:0]       bus_wdata_o,
    input  logic [dcache_pkg::DATA_W-1:0]       bus_rdata_i,
    input  logic                                bus_rdy_i
);

    localparam int NP = dcache_pkg::N_PORTS;

    dcache_pkg::lsu_op_e                op_in [NP], req_op [NP];
    logic [dcache_pkg::ADDR_W-1:0]      addr_in [NP], req_addr [NP], arb_addr [NP];
    logic [dcache_pkg::DATA_W-1:0]      wdata_in [NP], req_wdata [NP], arb_wdata [NP];
    logic [dcache_pkg::DATA_W-1:0]      rd_data [NP], wr_data [NP], rdata [NP];
    logic [dcache_pkg::INDEX_W-1:0]     rd_index [NP], wr_index [NP];
    logic [dcache_pkg::TAG_W-1:0]       rd_tag [NP], wr_tag [NP];
    logic [dcache_pkg::N_LANES-1:0]     wr_lanes [NP], arb_sel [NP];
    logic [NP-1:0]                      req_valid, busy, rd_valid, wr_en;
    logic [NP-1:0]                      arb_rq, arb_we, arb_rdy;

    assign op_in    = '{op_p0_i, op_p1_i};
    assign addr_in  = '{addr_p0_i, addr_p1_i};
    assign wdata_in = '{wdata_p0_i, wdata_p1_i};
    assign rdata_p0_o = rdata[0];
    assign rdata_p1_o = rdata[1];

    dcache_port_issue u_issue (
        .clk(clk), .rst(rst),
        .op_i(op_in), .addr_i(addr_in), .wdata_i(wdata_in), .busy_i(busy),
        .req_valid_o(req_valid), .req_op_o(req_op), .req_addr_o(req_addr),
        .req_wdata_o(req_wdata), .freeze_o(freeze_o)
    );

    for (genvar p = 0; p < NP; p++) begin : g_ctrl
        dcache_port_ctrl u_ctrl (
            .clk(clk), .rst(rst),
            .req_valid_i(req_valid[p]), .req_op_i(req_op[p]),
            .req_addr_i(req_addr[p]), .req_wdata_i(req_wdata[p]),
            .rd_valid_i(rd_valid[p]), .rd_tag_i(rd_tag[p]), .rd_data_i(rd_data[p]),
            .bus_rdy_i(arb_rdy[p]), .bus_rdata_i(bus_rdata_i),
            .rd_index_o(rd_index[p]), .wr_en_o(wr_en[p]), .wr_index_o(wr_index[p]),
            .wr_tag_o(wr_tag[p]), .wr_lanes_o(wr_lanes[p]), .wr_data_o(wr_data[p]),
            .bus_rq_o(arb_rq[p]), .bus_we_o(arb_we[p]), .bus_addr_o(arb_addr[p]),
            .bus_sel_o(arb_sel[p]), .bus_wdata_o(arb_wdata[p]),
            .rdata_o(rdata[p]), .busy_o(busy[p])
        );
    end

    dcache_store u_store (
        .clk(clk), .rst(rst),
        .rd_index_i(rd_index), .wr_en_i(wr_en), .wr_index_i(wr_index),
        .wr_tag_i(wr_tag), .wr_lanes_i(wr_lanes), .wr_data_i(wr_data),
        .rd_valid_o(rd_valid), .rd_tag_o(rd_tag), .rd_data_o(rd_data)
    );

    dcache_bus_arb u_arb (
        .clk(clk), .rst(rst),
        .rq_i(arb_rq), .we_i(arb_we), .addr_i(arb_addr), .sel_i(arb_sel),
        .wdata_i(arb_wdata), .bus_rdy_i(bus_rdy_i),
        .bus_rq_o(bus_rq_o), .bus_we_o(bus_we_o), .bus_addr_o(bus_addr_o),
        .bus_sel_o(bus_sel_o), .bus_wdata_o(bus_wdata_o), .rdy_o(arb_rdy)
    );

endmodule

/* hdl/dcache_bus_arb.sv */
// Bus arbiter that serves one controller at a time, lowest port first
`timescale 1ns/1ps

module dcache_bus_arb (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [dcache_pkg::N_PORTS-1:0]      rq_i,
    input  logic [dcache_pkg::N_PORTS-1:0]      we_i,
    input  logic [dcache_pkg::ADDR_W-1:0]       addr_i  [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::N_LANES-1:0]      sel_i   [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::DATA_W-1:0]       wdata_i [dcache_pkg::N_PORTS],
    input  logic                                bus_rdy_i,
    output logic                                bus_rq_o,
    output logic                                bus_we_o,
    output logic [dcache_pkg::ADDR_W-1:0]       bus_addr_o,
    output logic [dcache_pkg::N_LANES-1:0]      bus_sel_o,
    output logic [dcache_pkg::DATA_W-1:0]       bus_wdata_o,
    output logic [dcache_pkg::N_PORTS-1:0]      rdy_o
);

    logic [dcache_pkg::N_PORTS-1:0]   gnt_r;
    logic [dcache_pkg::N_PORTS-1:0]   gnt;

    always_comb begin
        gnt = gnt_r;
        if (gnt_r == '0) begin
            // Scan down so the lowest requester wins
            for (int p = dcache_pkg::N_PORTS - 1; p >= 0; p--) begin
                if (rq_i[p]) gnt = dcache_pkg::N_PORTS'(1) << p;
            end
        end
        bus_rq_o    = 1'b0;
        bus_we_o    = 1'b0;
        bus_addr_o  = '0;
        bus_sel_o   = '0;
        bus_wdata_o = '0;
        for (int p = 0; p < dcache_pkg::N_PORTS; p++) begin
            if (gnt[p]) begin
                bus_rq_o    = rq_i[p];
                bus_we_o    = we_i[p];
                bus_addr_o  = addr_i[p];
                bus_sel_o   = sel_i[p];
                bus_wdata_o = wdata_i[p];
            end
        end
    end

    assign rdy_o = gnt & {dcache_pkg::N_PORTS{bus_rdy_i}};

    always_ff @(posedge clk) begin
        if (rst || bus_rdy_i) begin
            gnt_r <= '0;                    // Transaction ends at ready
        end else begin
            gnt_r <= gnt;
        end
    end

    // Granted controller keeps its request up until ready
    a_gnt_held: assert property (@(posedge clk) disable iff (rst)
        (gnt_r != '0) |-> (|(gnt_r & rq_i)));

endmodule

/* hdl/dcache_store.sv */
// Direct-mapped line store with valid bits, tags and byte-writable words
`timescale 1ns/1ps

module dcache_store (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [dcache_pkg::INDEX_W-1:0]      rd_index_i [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::N_PORTS-1:0]      wr_en_i,
    input  logic [dcache_pkg::INDEX_W-1:0]      wr_index_i [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::TAG_W-1:0]        wr_tag_i   [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::N_LANES-1:0]      wr_lanes_i [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::DATA_W-1:0]       wr_data_i  [dcache_pkg::N_PORTS],
    output logic [dcache_pkg::N_PORTS-1:0]      rd_valid_o,
    output logic [dcache_pkg::TAG_W-1:0]        rd_tag_o   [dcache_pkg::N_PORTS],
    output logic [dcache_pkg::DATA_W-1:0]       rd_data_o  [dcache_pkg::N_PORTS]
);

    logic [dcache_pkg::N_LINES-1:0]   valid_r;
    logic [dcache_pkg::TAG_W-1:0]     tag_r  [dcache_pkg::N_LINES];
    logic [dcache_pkg::DATA_W-1:0]    data_r [dcache_pkg::N_LINES];

    always_comb begin
        for (int p = 0; p < dcache_pkg::N_PORTS; p++) begin
            rd_valid_o[p] = valid_r[rd_index_i[p]];
            rd_tag_o[p]   = tag_r[rd_index_i[p]];
            rd_data_o[p]  = data_r[rd_index_i[p]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
        end else begin
            for (int p = 0; p < dcache_pkg::N_PORTS; p++) begin
                if (wr_en_i[p]) valid_r[wr_index_i[p]] <= 1'b1;
            end
        end
    end

    // Lane-wise write, a store hit touches only its own bytes
    always_ff @(posedge clk) begin
        for (int p = 0; p < dcache_pkg::N_PORTS; p++) begin
            if (wr_en_i[p]) begin
                tag_r[wr_index_i[p]] <= wr_tag_i[p];
                for (int l = 0; l < dcache_pkg::N_LANES; l++) begin
                    if (wr_lanes_i[p][l]) begin
                        data_r[wr_index_i[p]][l*8 +: 8] <= wr_data_i[p][l*8 +: 8];
                    end
                end
            end
        end
    end

    // Issue ordering keeps the two controllers off the same line
    a_no_dual_write: assert property (@(posedge clk) disable iff (rst)
        !(wr_en_i[0] && wr_en_i[1] && (wr_index_i[0] == wr_index_i[1])));

endmodule

/* hdl/dcache_port_ctrl.sv */
// Port controller for hit check, line refill, write-through and load alignment
`timescale 1ns/1ps

module dcache_port_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                req_valid_i,
    input  dcache_pkg::lsu_op_e                 req_op_i,
    input  logic [dcache_pkg::ADDR_W-1:0]       req_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0]       req_wdata_i,
    input  logic                                rd_valid_i,
    input  logic [dcache_pkg::TAG_W-1:0]        rd_tag_i,
    input  logic [dcache_pkg::DATA_W-1:0]       rd_data_i,
    input  logic                                bus_rdy_i,
    input  logic [dcache_pkg::DATA_W-1:0]       bus_rdata_i,
    output logic [dcache_pkg::INDEX_W-1:0]      rd_index_o,
    output logic                                wr_en_o,
    output logic [dcache_pkg::INDEX_W-1:0]      wr_index_o,
    output logic [dcache_pkg::TAG_W-1:0]        wr_tag_o,
    output logic [dcache_pkg::N_LANES-1:0]      wr_lanes_o,
    output logic [dcache_pkg::DATA_W-1:0]       wr_data_o,
    output logic                                bus_rq_o,
    output logic                                bus_we_o,
    output logic [dcache_pkg::ADDR_W-1:0]       bus_addr_o,
    output logic [dcache_pkg::N_LANES-1:0]      bus_sel_o,
    output logic [dcache_pkg::DATA_W-1:0]       bus_wdata_o,
    output logic [dcache_pkg::DATA_W-1:0]       rdata_o,
    output logic                                busy_o
);

    dcache_pkg::ctrl_state_e               state_r;
    logic [dcache_pkg::DATA_W-1:0]         rdata_r;
    logic [dcache_pkg::INDEX_W-1:0]        idx;
    logic [dcache_pkg::TAG_W-1:0]          tag;
    logic [dcache_pkg::N_LANES-1:0]        lanes;
    logic [dcache_pkg::DATA_W-1:0]         st_data;
    logic                                  hit;
    logic                                  is_ld;
    logic                                  is_st;
    logic                                  in_idle;
    logic                                  refill_done;

    assign idx     = req_addr_i[dcache_pkg::INDEX_W+1:2];
    assign tag     = req_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::INDEX_W+2];
    assign lanes   = dcache_pkg::byte_lanes(req_op_i, req_addr_i[1:0]);
    assign st_data = dcache_pkg::store_align(req_op_i, req_addr_i[1:0], req_wdata_i);
    assign hit     = rd_valid_i && (rd_tag_i == tag);
    assign is_ld   = dcache_pkg::is_load(req_op_i);
    assign is_st   = dcache_pkg::is_store(req_op_i);
    assign in_idle = (state_r == dcache_pkg::IDLE) && req_valid_i;
    assign refill_done = (state_r == dcache_pkg::REFILL) && bus_rdy_i;

    ////////////////////////////////////////////////////////////////////////////
    // Line store side
    ////////////////////////////////////////////////////////////////////////////

    assign rd_index_o = idx;
    assign wr_index_o = idx;
    assign wr_tag_o   = tag;
    assign wr_en_o    = (in_idle && is_st && hit) || refill_done;   // Store hit or fill
    assign wr_lanes_o = (state_r == dcache_pkg::REFILL) ? '1 : lanes;
    assign wr_data_o  = (state_r == dcache_pkg::REFILL) ? bus_rdata_i : st_data;

    ////////////////////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////////////////////

    assign bus_rq_o    = (state_r == dcache_pkg::REFILL) || (state_r == dcache_pkg::WRITE);
    assign bus_we_o    = (state_r == dcache_pkg::WRITE);
    assign bus_addr_o  = {req_addr_i[dcache_pkg::ADDR_W-1:2], 2'b00};
    assign bus_sel_o   = bus_we_o ? lanes : '1;     // Refill reads the whole word
    assign bus_wdata_o = st_data;

    assign busy_o  = bus_rq_o || (in_idle && (is_st || !hit));
    assign rdata_o = rdata_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_r <= dcache_pkg::IDLE;
        end else begin
            case (state_r)
                dcache_pkg::IDLE: begin
                    if (req_valid_i && is_st) begin
                        state_r <= dcache_pkg::WRITE;
                    end else if (req_valid_i && is_ld && !hit) begin
                        state_r <= dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::REFILL, dcache_pkg::WRITE: begin
                    if (bus_rdy_i) state_r <= dcache_pkg::DONE;
                end
                default: state_r <= dcache_pkg::IDLE;   // Old request still registered
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_idle && is_ld && hit) begin
            rdata_r <= dcache_pkg::load_extract(req_op_i, req_addr_i[1:0], rd_data_i);
        end else if (refill_done) begin
            rdata_r <= dcache_pkg::load_extract(req_op_i, req_addr_i[1:0], bus_rdata_i);
        end
    end

    // A pending bus cycle must not move under the arbiter
    a_bus_steady: assert property (@(posedge clk) disable iff (rst)
        bus_rq_o && !bus_rdy_i |=> $stable(bus_addr_o) && $stable(bus_we_o));

endmodule

/* hdl/dcache_port_issue.sv */
// Issue stage that registers both port requests and orders same-index stores
`timescale 1ns/1ps

module dcache_port_issue (
    input  logic                                clk,
    input  logic                                rst,
    input  dcache_pkg::lsu_op_e                 op_i        [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::ADDR_W-1:0]       addr_i      [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::DATA_W-1:0]       wdata_i     [dcache_pkg::N_PORTS],
    input  logic [dcache_pkg::N_PORTS-1:0]      busy_i,
    output logic [dcache_pkg::N_PORTS-1:0]      req_valid_o,
    output dcache_pkg::lsu_op_e                 req_op_o    [dcache_pkg::N_PORTS],
    output logic [dcache_pkg::ADDR_W-1:0]       req_addr_o  [dcache_pkg::N_PORTS],
    output logic [dcache_pkg::DATA_W-1:0]       req_wdata_o [dcache_pkg::N_PORTS],
    output logic                                freeze_o
);

    dcache_pkg::issue_state_e              state_r;
    dcache_pkg::lsu_op_e                   op_r    [dcache_pkg::N_PORTS];
    logic [dcache_pkg::ADDR_W-1:0]         addr_r  [dcache_pkg::N_PORTS];
    logic [dcache_pkg::DATA_W-1:0]         wdata_r [dcache_pkg::N_PORTS];
    logic [dcache_pkg::N_PORTS-1:0]        pend_r;     // Captured, not yet taken
    logic                                  conflict;
    logic                                  hold_p1;

    // Both fresh, same line index, a store on either side
    assign conflict = (state_r == dcache_pkg::CHECK) && (&pend_r)
                   && (addr_r[0][dcache_pkg::INDEX_W+1:2] == addr_r[1][dcache_pkg::INDEX_W+1:2])
                   && (dcache_pkg::is_store(op_r[0]) || dcache_pkg::is_store(op_r[1]));

    // Port 0 state only, port 1 is idle while held
    assign hold_p1  = conflict || (state_r == dcache_pkg::HOLD && busy_i[0]);
    assign freeze_o = conflict || (state_r == dcache_pkg::HOLD) || (|busy_i);

    assign req_valid_o[0] = pend_r[0];
    assign req_valid_o[1] = pend_r[1] && !hold_p1;
    assign req_op_o    = op_r;
    assign req_addr_o  = addr_r;
    assign req_wdata_o = wdata_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_r <= dcache_pkg::CHECK;
            pend_r  <= '0;
            for (int p = 0; p < dcache_pkg::N_PORTS; p++) begin
                op_r[p] <= dcache_pkg::NOP;
            end
        end else begin
            if (!freeze_o) begin
                for (int p = 0; p < dcache_pkg::N_PORTS; p++) begin
                    op_r[p]   <= op_i[p];
                    pend_r[p] <= dcache_pkg::is_load(op_i[p]) || dcache_pkg::is_store(op_i[p]);
                end
            end else begin
                pend_r <= pend_r & ~req_valid_o;    // Taken by a controller
            end
            case (state_r)
                dcache_pkg::CHECK: if (conflict) state_r <= dcache_pkg::HOLD;
                default:           if (!busy_i[0]) state_r <= dcache_pkg::CHECK;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_o) begin
            addr_r  <= addr_i;
            wdata_r <= wdata_i;
        end
    end

endmodule

/* hdl/dcache_pkg.sv */
// Data cache package with sizes, opcode and state types, and lane helpers
package dcache_pkg;

    localparam int N_PORTS = 2;            // Processor ports
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int N_LANES = DATA_W / 8;
    localparam int INDEX_W = 7;            // Address bits 8:2
    localparam int N_LINES = 1 << INDEX_W;
    localparam int TAG_W   = ADDR_W - INDEX_W - 2;

    typedef enum logic [3:0] {
        NOP, LB, LBU, LH, LHU, LW, SB, SH, SW
    } lsu_op_e;

    typedef enum logic [1:0] {IDLE, REFILL, WRITE, DONE} ctrl_state_e;

    typedef enum logic {CHECK, HOLD} issue_state_e;

    function automatic logic is_load(lsu_op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic logic is_store(lsu_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    // Lane mask by access size
    function automatic logic [N_LANES-1:0] byte_lanes(lsu_op_e op, logic [1:0] lo);
        case (op)
            LB, LBU, SB: return N_LANES'(1) << lo;
            LH, LHU, SH: return lo[1] ? 4'b1100 : 4'b0011;
            LW, SW:      return '1;
            default:     return '0;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] store_align(lsu_op_e op, logic [1:0] lo,
                                                      logic [DATA_W-1:0] data);
        case (op)
            SB:      return DATA_W'(data[7:0]) << {lo, 3'b000};
            SH:      return DATA_W'(data[15:0]) << {lo[1], 4'b0000};
            default: return data;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] load_extract(lsu_op_e op, logic [1:0] lo,
                                                       logic [DATA_W-1:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[{lo, 3'b000} +: 8];
        h = lo[1] ? word[31:16] : word[15:0];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'd0, h};
            default: return word;
        endcase
    endfunction

endpackage
